// File: common/bch_pkg.sv
`default_nettype none

package bch_pkg;

    // BCH(15,7) double-error-correcting code over GF(16)
    localparam int CODE_N = 15;
    localparam int CODE_K = 7;
    localparam int GF_M   = 4;

    // x^4 + x + 1 with the x^4 term dropped
    localparam logic [GF_M-1:0] GF_POLY = 4'b0011;

    typedef logic [GF_M-1:0]   gf_t;   // field element, polynomial basis
    typedef logic [CODE_N-1:0] cw_t;   // bit i is the coefficient of x^i
    typedef logic [1:0]        cnt_t;  // error count 0..2

    // shift-and-add product, reduced on every shift
    function automatic gf_t gf_mul(input gf_t a, input gf_t b);
        gf_t acc;
        gf_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < GF_M; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = sh[GF_M-1] ? ((sh << 1) ^ GF_POLY) : (sh << 1);
        end
        return acc;
    endfunction

    // exhaustive search, only 15 candidates
    function automatic gf_t gf_inv(input gf_t a);
        gf_t res;
        res = '0;  // zero has no inverse
        for (int b = 1; b < (1 << GF_M); b++) begin
            if (gf_mul(a, gf_t'(b)) == gf_t'(1)) begin
                res = gf_t'(b);
            end
        end
        return res;
    endfunction

    // alpha^e for e in 0..14
    function automatic gf_t gf_alpha_pow(input logic [GF_M-1:0] e);
        gf_t res;
        case (e)
            4'd0:    res = 4'b0001;
            4'd1:    res = 4'b0010;
            4'd2:    res = 4'b0100;
            4'd3:    res = 4'b1000;
            4'd4:    res = 4'b0011;
            4'd5:    res = 4'b0110;
            4'd6:    res = 4'b1100;
            4'd7:    res = 4'b1011;
            4'd8:    res = 4'b0101;
            4'd9:    res = 4'b1010;
            4'd10:   res = 4'b0111;
            4'd11:   res = 4'b1110;
            4'd12:   res = 4'b1111;
            4'd13:   res = 4'b1101;
            4'd14:   res = 4'b1001;
            default: res = 4'b0001;  // alpha^15 wraps to one
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

// File: source/bch_syndrome.sv
`timescale 1ns/1ps
`default_nettype none

module bch_syndrome import bch_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic word_valid,
    input  cw_t  word,
    output logic syn_valid,
    output cw_t  syn_word,
    output gf_t  syn_s1,
    output gf_t  syn_s3
);

    gf_t s1;
    gf_t s3;

    // r(alpha) and r(alpha^3) as sums of powers over the set bits;
    // S2 and S4 follow from S1 for a binary code, so only odd ones are needed
    always_comb begin
        s1 = '0;
        s3 = '0;
        for (int i = 0; i < CODE_N; i++) begin
            if (word[i]) begin
                s1 = s1 ^ gf_alpha_pow(GF_M'(i));
                s3 = s3 ^ gf_alpha_pow(GF_M'((3 * i) % CODE_N));  // exponent mod 15
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syn_valid <= 1'b0;
        end else begin
            syn_valid <= word_valid;
        end
    end

    // word and syndromes only load with a valid word
    always_ff @(posedge clk) begin
        if (word_valid) begin
            syn_word <= word;
            syn_s1   <= s1;
            syn_s3   <= s3;
        end
    end

endmodule

`default_nettype wire

// File: source/bch_locator.sv
`timescale 1ns/1ps
`default_nettype none

module bch_locator import bch_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic syn_valid,
    input  cw_t  syn_word,
    input  gf_t  syn_s1,
    input  gf_t  syn_s3,
    output logic loc_valid,
    output cw_t  loc_word,
    output gf_t  loc_sigma1,
    output gf_t  loc_sigma2,
    output cnt_t loc_degree,
    output logic loc_bad
);

    gf_t  s1_sq;
    gf_t  s1_cubed;
    gf_t  sigma1;
    gf_t  sigma2;
    cnt_t degree;
    logic bad;

    // Peterson direct solution for t = 2
    always_comb begin
        s1_sq    = gf_mul(syn_s1, syn_s1);
        s1_cubed = gf_mul(s1_sq, syn_s1);
        sigma1   = '0;
        sigma2   = '0;
        degree   = '0;
        bad      = 1'b0;
        if (syn_s1 == '0) begin
            bad = (syn_s3 != '0);  // S3 alone means more than two errors
        end else if (syn_s3 == s1_cubed) begin
            degree = 2'd1;  // single error at S1
            sigma1 = syn_s1;
        end else begin
            degree = 2'd2;
            sigma1 = syn_s1;
            // sigma2 = (S3 + S1^3) / S1
            sigma2 = gf_mul(syn_s3 ^ s1_cubed, gf_inv(syn_s1));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loc_valid <= 1'b0;
        end else begin
            loc_valid <= syn_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (syn_valid) begin
            loc_word   <= syn_word;
            loc_sigma1 <= sigma1;
            loc_sigma2 <= sigma2;
            loc_degree <= degree;
            loc_bad    <= bad;
        end
    end

endmodule

`default_nettype wire

// File: source/bch_chien.sv
`timescale 1ns/1ps
`default_nettype none

module bch_chien import bch_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic loc_valid,
    input  cw_t  loc_word,
    input  gf_t  loc_sigma1,
    input  gf_t  loc_sigma2,
    input  cnt_t loc_degree,
    input  logic loc_bad,
    output logic out_valid,
    output cw_t  out_word,
    output cnt_t out_count,
    output logic out_fail
);

    localparam int CNT_W = $clog2(CODE_N + 1);

    gf_t              x_inv;
    gf_t              x_inv_sq;
    gf_t              eval;
    cw_t              mask;
    logic [CNT_W-1:0] root_cnt;
    logic             fail;

    // all 15 positions at once, error at i when sigma(alpha^-i) is zero
    always_comb begin
        mask     = '0;
        root_cnt = '0;
        x_inv    = '0;
        x_inv_sq = '0;
        eval     = '0;
        for (int i = 0; i < CODE_N; i++) begin
            x_inv    = gf_alpha_pow(GF_M'((CODE_N - i) % CODE_N));
            x_inv_sq = gf_mul(x_inv, x_inv);
            eval     = gf_t'(1) ^ gf_mul(loc_sigma1, x_inv) ^ gf_mul(loc_sigma2, x_inv_sq);
            if (eval == '0) begin
                mask[i]  = 1'b1;
                root_cnt = root_cnt + 1'b1;
            end
        end
    end

    // a locator whose roots are not all in the field means too many errors
    assign fail = loc_bad | (root_cnt != CNT_W'(loc_degree));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_word  <= '0;
            out_count <= '0;
            out_fail  <= 1'b0;
        end else begin
            out_valid <= loc_valid;
            if (loc_valid) begin
                out_fail <= fail;
                if (fail) begin
                    out_word  <= loc_word;  // uncorrectable, pass as received
                    out_count <= '0;
                end else begin
                    out_word  <= loc_word ^ mask;
                    out_count <= loc_degree;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/bch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bch_decoder import bch_pkg::*; #(
    parameter int MAX_CREDITS = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  cw_t  in_word,
    output logic in_ready,
    input  logic out_credit,
    output logic out_valid,
    output cw_t  out_word,
    output cnt_t out_count,
    output logic out_fail
);

    localparam int CREDIT_W = $clog2(MAX_CREDITS + 1);

    logic [CREDIT_W-1:0] credits;
    logic                accept;

    // input capture stage
    logic in_valid_q;
    cw_t  in_word_q;

    // syndrome stage outputs
    logic syn_valid;
    cw_t  syn_word;
    gf_t  syn_s1;
    gf_t  syn_s3;

    // locator stage outputs
    logic loc_valid;
    cw_t  loc_word;
    gf_t  loc_sigma1;
    gf_t  loc_sigma2;
    cnt_t loc_degree;
    logic loc_bad;

    // each slot held by the consumer lets one word enter
    assign in_ready = (credits != '0);
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= '0;
        end else begin
            case ({out_credit, accept})
                2'b10: begin
                    if (credits != CREDIT_W'(MAX_CREDITS)) begin
                        credits <= credits + 1'b1;
                    end
                end
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;  // idle or pulse and accept cancel
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            in_word_q <= in_word;
        end
    end

    bch_syndrome i_bch_syndrome (
        .clk        (clk),
        .rst        (rst),
        .word_valid (in_valid_q),
        .word       (in_word_q),
        .syn_valid  (syn_valid),
        .syn_word   (syn_word),
        .syn_s1     (syn_s1),
        .syn_s3     (syn_s3)
    );

    bch_locator i_bch_locator (
        .clk        (clk),
        .rst        (rst),
        .syn_valid  (syn_valid),
        .syn_word   (syn_word),
        .syn_s1     (syn_s1),
        .syn_s3     (syn_s3),
        .loc_valid  (loc_valid),
        .loc_word   (loc_word),
        .loc_sigma1 (loc_sigma1),
        .loc_sigma2 (loc_sigma2),
        .loc_degree (loc_degree),
        .loc_bad    (loc_bad)
    );

    bch_chien i_bch_chien (
        .clk        (clk),
        .rst        (rst),
        .loc_valid  (loc_valid),
        .loc_word   (loc_word),
        .loc_sigma1 (loc_sigma1),
        .loc_sigma2 (loc_sigma2),
        .loc_degree (loc_degree),
        .loc_bad    (loc_bad),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .out_count  (out_count),
        .out_fail   (out_fail)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 10  // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: bench/bch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bch_checker import bch_pkg::*; #(
    parameter int MAX_CREDITS = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  cw_t  in_word,
    input  logic in_ready,
    input  logic out_credit,
    input  logic out_valid,
    input  cw_t  out_word,
    input  cnt_t out_count,
    input  logic out_fail,
    input  int   test_idx,
    input  logic test_end,
    input  int   burst_len,
    output logic idle,
    output int   words_checked,
    output int   err_total
);

    localparam logic [8:0] GEN_POLY = 9'h1d1;
    // accepted at edge E, out_valid set at E+3 and sampled at E+4
    localparam int LATENCY = 4;

    cw_t  code_table [128];
    cw_t  exp_word_q [$];
    cnt_t exp_count_q [$];
    logic exp_fail_q [$];
    int   accept_cycle_q [$];

    int cycle        = 0;
    int credit_model = 0;
    int granted      = 0;
    int outputs      = 0;
    int in_flight    = 0;
    int run_cur      = 0;
    int run_max      = 0;
    int test_words   = 0;
    int test_errs    = 0;

    assign idle = (in_flight == 0);

    // every code word is a multiple of g(x)
    function automatic cw_t times_gen(input logic [CODE_K-1:0] m);
        cw_t p;
        p = '0;
        for (int i = 0; i < CODE_K; i++) begin
            if (m[i]) begin
                p = p ^ (cw_t'(GEN_POLY) << i);
            end
        end
        return p;
    endfunction

    // brute force: nearest code word within distance 2, unique since d_min is 5
    function automatic void ref_decode(input cw_t r, output cw_t word, output cnt_t count,
                                       output logic fail);
        int d;
        word  = r;
        count = '0;
        fail  = 1'b1;
        for (int k = 0; k < 128; k++) begin
            d = $countones(r ^ code_table[k]);
            if (d <= 2) begin
                word  = code_table[k];
                count = cnt_t'(d);
                fail  = 1'b0;
            end
        end
    endfunction

    function automatic string test_title(input int idx);
        case (idx)
            1:       return "no entry without credit";
            2:       return "clean code words";
            3:       return "single error at each position";
            4:       return "double errors";
            5:       return "three and four errors";
            6:       return "slow credits";
            7:       return "full rate burst";
            default: return "unnamed";
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        test_errs++;
        err_total++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s (at %0t)", msg, $time);
        test_errs++;
        err_total++;
    endtask

    initial begin
        for (int m = 0; m < 128; m++) begin
            code_table[m] = times_gen(CODE_K'(m));
        end
        words_checked = 0;
        err_total     = 0;
    end

    always @(posedge clk) begin : watch
        cw_t  w;
        cnt_t c;
        logic f;
        int   lat;
        if (rst) begin
            credit_model = 0;
            run_cur      = 0;
        end else begin
            cycle++;
            if (in_ready !== (credit_model != 0)) begin
                report_error($sformatf("in_ready %b with %0d credits", in_ready, credit_model));
            end
            if (in_valid && in_ready) begin
                ref_decode(in_word, w, c, f);
                exp_word_q.push_back(w);
                exp_count_q.push_back(c);
                exp_fail_q.push_back(f);
                accept_cycle_q.push_back(cycle);
                in_flight++;
            end
            // saturating slot count, a grant and an entry in one cycle cancel
            if (out_credit) begin
                granted++;
            end
            if (out_credit && !(in_valid && in_ready)) begin
                credit_model = (credit_model < MAX_CREDITS) ? credit_model + 1 : MAX_CREDITS;
            end else if (!out_credit && in_valid && in_ready) begin
                credit_model--;
            end

            if (out_valid) begin
                outputs++;
                run_cur++;
                run_max = (run_cur > run_max) ? run_cur : run_max;
                if (outputs > granted) begin
                    report_problem($sformatf("more outputs (%0d) than credits granted (%0d)",
                                             outputs, granted));
                end
                if (in_flight == 0) begin
                    report_problem($sformatf("output word %h appeared with nothing in flight",
                                             out_word));
                end else begin
                    w   = exp_word_q.pop_front();
                    c   = exp_count_q.pop_front();
                    f   = exp_fail_q.pop_front();
                    lat = cycle - accept_cycle_q.pop_front();
                    in_flight--;
                    words_checked++;
                    test_words++;
                    if (out_word !== w || out_count !== c || out_fail !== f) begin
                        report_error($sformatf("got %h count %0d fail %b, expected %h count %0d fail %b",
                                               out_word, out_count, out_fail, w, c, f));
                    end
                    if (lat != LATENCY) begin
                        report_error($sformatf("output came %0d cycles after acceptance", lat - 1));
                    end
                end
            end else begin
                run_cur = 0;
            end

            if (test_end) begin
                if (burst_len > 0 && run_max < burst_len) begin
                    report_error($sformatf("longest output run %0d cycles, expected %0d",
                                           run_max, burst_len));
                end
                $display("test %0d %s: %0d words, %0d errors, %s", test_idx,
                         test_title(test_idx), test_words, test_errs,
                         (test_errs == 0) ? "ok" : "failed");
                test_words = 0;
                test_errs  = 0;
                run_max    = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/bch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bch_tb import bch_pkg::*; ();

    localparam int          MAX_CREDITS = 8;
    localparam logic [31:0] SEED        = 32'h7c615404;
    localparam logic [8:0]  GEN_POLY    = 9'h1d1;  // x^8 + x^7 + x^6 + x^4 + 1

    localparam int N_CLEAN   = 20;
    localparam int N_PER_POS = 4;   // words per flipped position
    localparam int N_DOUBLE  = 150;
    localparam int N_MULTI   = 150;
    localparam int N_SLOW    = 100;
    localparam int N_BURST   = 60;
    localparam int MAX_GAP   = 6;   // idle cycles between slow credits

    localparam int TOTAL_WORDS = 1 + N_CLEAN + CODE_N * N_PER_POS + N_DOUBLE + N_MULTI
                                 + N_SLOW + N_BURST;
    // worst case one credit per MAX_GAP + 1 cycles, plus drain time per test
    localparam int TIMEOUT_CYCLES = TOTAL_WORDS * (MAX_GAP + 2) + 7 * 100;

    localparam int CR_NONE = 0;
    localparam int CR_FULL = 1;
    localparam int CR_SLOW = 2;

    logic clk;
    logic rst;
    logic in_valid;
    cw_t  in_word;
    logic in_ready;
    logic out_credit;
    logic out_valid;
    cw_t  out_word;
    cnt_t out_count;
    logic out_fail;

    int   credit_mode;
    int   test_idx;
    logic test_end;
    int   burst_len;
    logic idle;
    int   words_checked;
    int   err_total;
    cw_t  w;

    tb_clock #(.PERIOD(10)) i_tb_clock (.clk(clk));

    bch_decoder #(.MAX_CREDITS(MAX_CREDITS)) i_bch_decoder (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .in_ready   (in_ready),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .out_count  (out_count),
        .out_fail   (out_fail)
    );

    bch_checker #(.MAX_CREDITS(MAX_CREDITS)) i_bch_checker (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_word       (in_word),
        .in_ready      (in_ready),
        .out_credit    (out_credit),
        .out_valid     (out_valid),
        .out_word      (out_word),
        .out_count     (out_count),
        .out_fail      (out_fail),
        .test_idx      (test_idx),
        .test_end      (test_end),
        .burst_len     (burst_len),
        .idle          (idle),
        .words_checked (words_checked),
        .err_total     (err_total)
    );

    // systematic: message on top, remainder mod g(x) in the low 8 bits
    function automatic cw_t encode(input logic [CODE_K-1:0] msg);
        cw_t rem;
        rem = cw_t'(msg) << (CODE_N - CODE_K);
        for (int i = CODE_N - 1; i >= CODE_N - CODE_K; i--) begin
            if (rem[i]) begin
                rem = rem ^ (cw_t'(GEN_POLY) << (i - 8));
            end
        end
        return {msg, rem[7:0]};
    endfunction

    function automatic cw_t random_codeword();
        return encode(CODE_K'($urandom_range(127, 0)));
    endfunction

    function automatic cw_t flip_random(input cw_t word, input int n);
        cw_t mask;
        mask = '0;
        while ($countones(mask) < n) begin
            mask[$urandom_range(CODE_N - 1, 0)] = 1'b1;  // distinct positions
        end
        return word ^ mask;
    endfunction

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_word(input cw_t word);
        in_valid = 1'b1;
        in_word  = word;
        while (!in_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic end_test(input int burst);
        while (!idle) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        burst_len = burst;
        test_end  = 1'b1;
        @(negedge clk);
        test_end  = 1'b0;
        burst_len = 0;
    endtask

    // consumer side credit pulses
    initial begin : credit_gen
        int gap;
        gap        = 0;
        out_credit = 1'b0;
        forever begin
            @(negedge clk);
            if (credit_mode == CR_FULL) begin
                out_credit = 1'b1;
            end else if (credit_mode == CR_SLOW && gap == 0) begin
                out_credit = 1'b1;
                gap        = $urandom_range(MAX_GAP, 1);
            end else begin
                out_credit = 1'b0;
                gap        = (gap > 0) ? gap - 1 : 0;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_word     = '0;
        credit_mode = CR_NONE;
        test_idx    = 0;
        test_end    = 1'b0;
        burst_len   = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // word waits at the input until the first credit arrives
        test_idx = 1;
        w        = encode(7'h5a);
        in_valid = 1'b1;
        in_word  = w;
        repeat (6) @(negedge clk);
        credit_mode = CR_SLOW;
        send_word(w);
        end_test(0);

        test_idx    = 2;
        credit_mode = CR_FULL;
        for (int k = 0; k < N_CLEAN; k++) begin
            send_word(random_codeword());
        end
        end_test(0);

        test_idx = 3;
        for (int pos = 0; pos < CODE_N; pos++) begin
            for (int k = 0; k < N_PER_POS; k++) begin
                w      = random_codeword();
                w[pos] = ~w[pos];
                send_word(w);
            end
        end
        end_test(0);

        test_idx = 4;
        for (int k = 0; k < N_DOUBLE; k++) begin
            send_word(flip_random(random_codeword(), 2));
        end
        end_test(0);

        test_idx = 5;
        for (int k = 0; k < N_MULTI; k++) begin
            send_word(flip_random(random_codeword(), 3 + int'($urandom_range(1, 0))));
        end
        end_test(0);

        test_idx    = 6;
        credit_mode = CR_SLOW;
        for (int k = 0; k < N_SLOW; k++) begin
            send_word(flip_random(random_codeword(), int'($urandom_range(2, 0))));
        end
        end_test(0);

        test_idx    = 7;
        credit_mode = CR_FULL;
        for (int k = 0; k < N_BURST; k++) begin
            send_word(flip_random(random_codeword(), int'($urandom_range(4, 0))));
        end
        end_test(N_BURST);

        @(negedge clk);
        $display("%0d words checked, %0d errors", words_checked, err_total);
        if (err_total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
common/bch_pkg.sv
source/bch_syndrome.sv
source/bch_locator.sv
source/bch_chien.sv
source/bch_decoder.sv
bench/tb_clock.sv
bench/bch_checker.sv
bench/bch_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0 -Wno-fatal
TOP      = bch_tb
FILELIST = tb.f
OBJ_DIR  = obj_dir

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
